/* Makefile */
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = cache_mem_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Something failed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') verification/cache_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@echo "no failure found in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/cache_array.sv */
// line storage with two combinational set reads and one line write per cycle
`timescale 1ns/1ps
`default_nettype none

module cache_array (
	input logic clock,
	input logic reset,
	wr_req_if.sink wr,
	input cache_pkg::way_idx_t wr_way,
	input cache_pkg::set_idx_t rd_idx,
	output cache_pkg::set_lines_t rd_set,
	output cache_pkg::set_lines_t wr_set
);

	cache_pkg::set_lines_t sets [cache_pkg::num_sets];

	// read port for lookups
	assign rd_set = sets[rd_idx];

	// second read port feeds the write-side comparator and victim logic
	assign wr_set = sets[wr.idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < cache_pkg::num_sets; s++) begin
				for (int w = 0; w < cache_pkg::num_ways; w++) begin
					sets[s][w].valid <= 1'b0;
					sets[s][w].tag <= '0;
				end
			end
		end else if (wr.en) begin
			// incoming line is always marked valid
			sets[wr.idx][wr_way].valid <= 1'b1;
			sets[wr.idx][wr_way].tag <= wr.tag;
			sets[wr.idx][wr_way].data <= wr.data;
		end
	end

endmodule

`default_nettype wire

/* rtl/cache_mem.sv */
// cache top with an 8x4 set-associative line store and one read and one write port
`timescale 1ns/1ps
`default_nettype none

module cache_mem (
	input logic clock,
	input logic reset,
	input logic wr_en,
	input cache_pkg::set_idx_t wr_idx,
	input cache_pkg::tag_t wr_tag,
	input cache_pkg::data_t wr_data,
	input cache_pkg::set_idx_t rd_idx,
	input cache_pkg::tag_t rd_tag,
	output cache_pkg::data_t rd_data,
	output logic rd_valid
);

	wr_req_if wr ();

	cache_pkg::set_lines_t rd_set;
	cache_pkg::set_lines_t wr_set;
	cache_pkg::way_vec_t rd_hits;
	cache_pkg::way_vec_t wr_hits;
	cache_pkg::way_vec_t wr_valids;
	cache_pkg::way_idx_t rd_way;
	cache_pkg::way_idx_t wr_way;
	logic rd_any;

	assign wr.en = wr_en;
	assign wr.idx = wr_idx;
	assign wr.tag = wr_tag;
	assign wr.data = wr_data;

	cache_array u_array (
		.clock(clock),
		.reset(reset),
		.wr(wr),
		.wr_way(wr_way),
		.rd_idx(rd_idx),
		.rd_set(rd_set),
		.wr_set(wr_set)
	);

	// read side
	tag_cam u_rd_cam (
		.tags(rd_set),
		.key(rd_tag),
		.hits(rd_hits)
	);

	way_encoder u_rd_enc (
		.in(rd_hits),
		.out(rd_way),
		.any(rd_any)
	);

	// write side
	tag_cam u_wr_cam (
		.tags(wr_set),
		.key(wr.tag),
		.hits(wr_hits)
	);

	always_comb begin
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			wr_valids[w] = wr_set[w].valid;
		end
	end

	victim_select u_victim (
		.clock(clock),
		.reset(reset),
		.wr(wr),
		.hits(wr_hits),
		.valids(wr_valids),
		.way(wr_way)
	);

	assign rd_valid = rd_any;
	// zero on a miss
	assign rd_data = rd_any ? rd_set[rd_way].data : '0;

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
// cache geometry constants, index and payload types, line and set types
`default_nettype none

package cache_pkg;

	// 8 sets by 4 ways
	localparam int num_sets = 8;
	localparam int num_ways = 4;

	// index widths follow from the geometry
	localparam int set_bits = $clog2(num_sets);
	localparam int way_bits = $clog2(num_ways);

	// line payload widths
	localparam int tag_bits = 10;
	localparam int data_bits = 64;

	typedef logic [set_bits-1:0] set_idx_t;
	typedef logic [way_bits-1:0] way_idx_t;
	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [data_bits-1:0] data_t;

	// one bit per way with bit n for way n
	typedef logic [num_ways-1:0] way_vec_t;

	// 1 + 10 + 64 = 75 bits
	typedef struct packed {
		logic valid;
		tag_t tag;
		data_t data;
	} line_t;

	// all ways of one set with element n for way n
	typedef line_t [num_ways-1:0] set_lines_t;

endpackage

`default_nettype wire

/* rtl/tag_cam.sv */
// tag comparator across the ways of one set, qualified by valid
`timescale 1ns/1ps
`default_nettype none

module tag_cam (
	input cache_pkg::set_lines_t tags,
	input cache_pkg::tag_t key,
	output cache_pkg::way_vec_t hits
);

	cache_pkg::way_vec_t valid_bits;
	cache_pkg::way_vec_t tag_eq;

	// split the two conditions per way
	always_comb begin
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			valid_bits[w] = tags[w].valid;
			tag_eq[w] = (tags[w].tag == key);
		end
	end

	// stale tags in invalid ways never match
	assign hits = valid_bits & tag_eq;

endmodule

`default_nettype wire

/* rtl/victim_select.sv */
// write way selection by hit way, then first free way, then round-robin pointer
`timescale 1ns/1ps
`default_nettype none

module victim_select (
	input logic clock,
	input logic reset,
	wr_req_if.sink wr,
	input cache_pkg::way_vec_t hits,
	input cache_pkg::way_vec_t valids,
	output cache_pkg::way_idx_t way
);

	cache_pkg::way_idx_t ptr [cache_pkg::num_sets];

	cache_pkg::way_idx_t hit_way;
	logic hit_any;
	cache_pkg::way_idx_t free_way;
	logic free_any;
	cache_pkg::way_vec_t invalids;
	logic replace;

	assign invalids = ~valids;

	way_encoder u_hit_enc (
		.in(hits),
		.out(hit_way),
		.any(hit_any)
	);

	way_encoder u_free_enc (
		.in(invalids),
		.out(free_way),
		.any(free_any)
	);

	always_comb begin
		if (hit_any) begin
			way = hit_way;
		end else if (free_any) begin
			way = free_way;
		end else begin
			way = ptr[wr.idx];
		end
	end

	// only a miss into a full set consumes the pointer
	assign replace = wr.en && !hit_any && !free_any;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < cache_pkg::num_sets; s++) begin
				ptr[s] <= '0;
			end
		end else if (replace) begin
			// wraps modulo num_ways by width
			ptr[wr.idx] <= ptr[wr.idx] + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/way_encoder.sv */
// priority encoder for the lowest set way with an any flag
`timescale 1ns/1ps
`default_nettype none

module way_encoder (
	input cache_pkg::way_vec_t in,
	output cache_pkg::way_idx_t out,
	output logic any
);

	// scan from the top so the lowest index is the last to assign
	always_comb begin
		out = '0;
		for (int w = cache_pkg::num_ways - 1; w >= 0; w--) begin
			if (in[w]) begin
				out = cache_pkg::way_idx_t'(w);
			end
		end
	end

	assign any = |in;

endmodule

`default_nettype wire

/* rtl/wr_req_if.sv */
// write request bundle with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface wr_req_if;

	// single-cycle strobe, one write per high cycle
	logic en;
	cache_pkg::set_idx_t idx;
	cache_pkg::tag_t tag;
	cache_pkg::data_t data;

	modport source (
		output en,
		output idx,
		output tag,
		output data
	);

	modport sink (
		input en,
		input idx,
		input tag,
		input data
	);

endinterface

`default_nettype wire

/* tb.f */
rtl/cache_pkg.sv
rtl/wr_req_if.sv
rtl/tag_cam.sv
rtl/way_encoder.sv
rtl/victim_select.sv
rtl/cache_array.sv
rtl/cache_mem.sv
+incdir+verification
verification/cache_mem_tb.sv

/* verification/cache_model.svh */
// reference model state, write and read reference functions, compare task
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

bit model_valid [cache_pkg::num_sets][cache_pkg::num_ways];
cache_pkg::tag_t model_tag [cache_pkg::num_sets][cache_pkg::num_ways];
cache_pkg::data_t model_data [cache_pkg::num_sets][cache_pkg::num_ways];
int model_ptr [cache_pkg::num_sets];

int error_count = 0;
int check_count = 0;

function automatic void model_reset();
	for (int s = 0; s < cache_pkg::num_sets; s++) begin
		model_ptr[s] = 0;
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			model_valid[s][w] = 1'b0;
			model_tag[s][w] = '0;
			model_data[s][w] = '0;
		end
	end
endfunction

// hit way first, then lowest free way, then the set's round-robin pointer
function automatic void model_write(input cache_pkg::set_idx_t idx, input cache_pkg::tag_t tag,
		input cache_pkg::data_t data);
	int way;
	bit found;
	way = 0;
	found = 1'b0;
	for (int w = 0; w < cache_pkg::num_ways; w++) begin
		if (!found && model_valid[idx][w] && model_tag[idx][w] == tag) begin
			way = w;
			found = 1'b1;
		end
	end
	for (int w = 0; w < cache_pkg::num_ways; w++) begin
		if (!found && !model_valid[idx][w]) begin
			way = w;
			found = 1'b1;
		end
	end
	if (!found) begin
		way = model_ptr[idx];
		model_ptr[idx] = (model_ptr[idx] + 1) % cache_pkg::num_ways;
	end
	model_valid[idx][way] = 1'b1;
	model_tag[idx][way] = tag;
	model_data[idx][way] = data;
endfunction

// returns the hit flag and gives zero data on a miss
function automatic bit model_read(input cache_pkg::set_idx_t idx, input cache_pkg::tag_t tag,
		output cache_pkg::data_t data);
	bit hit;
	hit = 1'b0;
	data = '0;
	for (int w = 0; w < cache_pkg::num_ways; w++) begin
		if (!hit && model_valid[idx][w] && model_tag[idx][w] == tag) begin
			hit = 1'b1;
			data = model_data[idx][w];
		end
	end
	return hit;
endfunction

task automatic check_value(input string name, input cache_pkg::data_t expected,
		input cache_pkg::data_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
	end
endtask

`endif

/* verification/cache_mem_tb.sv */
// cache_mem testbench with clock, reset, directed and random stimulus, checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module cache_mem_tb;

	localparam int clk_period = 40;
	localparam int drive_delay = 2;
	localparam int sample_delay = clk_period - drive_delay;
	localparam int reset_cycles = 4;
	localparam int directed_cycles = 73;
	localparam int random_cycles = 400;
	localparam int test_cycles = reset_cycles + directed_cycles + random_cycles;
	localparam int watchdog_time = (test_cycles + 100) * clk_period;

	logic clock;
	logic reset;
	logic wr_en;
	cache_pkg::set_idx_t wr_idx;
	cache_pkg::tag_t wr_tag;
	cache_pkg::data_t wr_data;
	cache_pkg::set_idx_t rd_idx;
	cache_pkg::tag_t rd_tag;
	cache_pkg::data_t rd_data;
	logic rd_valid;

	integer seed = 62287;

	`include "cache_model.svh"

	cache_mem u_dut (
		.clock(clock),
		.reset(reset),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_tag(wr_tag),
		.wr_data(wr_data),
		.rd_idx(rd_idx),
		.rd_tag(rd_tag),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clk_period / 2) clock = ~clock;
		end
	end

	function automatic cache_pkg::data_t random_data();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	function automatic cache_pkg::tag_t random_tag();
		logic [31:0] r;
		r = $random(seed);
		return r[cache_pkg::tag_bits-1:0];
	endfunction

	// one cycle of inputs just after the rising edge
	task automatic drive_cycle(input logic we, input cache_pkg::set_idx_t widx,
			input cache_pkg::tag_t wtag, input cache_pkg::data_t wdata,
			input cache_pkg::set_idx_t ridx, input cache_pkg::tag_t rtag);
		@(posedge clock);
		#(drive_delay);
		wr_en = we;
		wr_idx = widx;
		wr_tag = wtag;
		wr_data = wdata;
		rd_idx = ridx;
		rd_tag = rtag;
	endtask

	task automatic read_line(input cache_pkg::set_idx_t idx, input cache_pkg::tag_t tag);
		drive_cycle(1'b0, '0, '0, '0, idx, tag);
	endtask

	task automatic write_line(input cache_pkg::set_idx_t idx, input cache_pkg::tag_t tag,
			input cache_pkg::data_t data);
		drive_cycle(1'b1, idx, tag, data, '0, '0);
	endtask

	// compare the read port just before each edge and then apply the write of that cycle
	initial begin
		bit exp_hit;
		cache_pkg::data_t exp_data;
		model_reset();
		forever begin
			@(posedge clock);
			#(sample_delay);
			if (reset) begin
				model_reset();
			end else begin
				exp_hit = model_read(rd_idx, rd_tag, exp_data);
				check_value("rd_valid", cache_pkg::data_t'(exp_hit), cache_pkg::data_t'(rd_valid));
				check_value("rd_data", exp_data, rd_data);
				if (wr_en) begin
					model_write(wr_idx, wr_tag, wr_data);
				end
			end
		end
	end

	initial begin
		#(watchdog_time);
		$display("timeout: simulation did not finish within %0d ns, the run hung", watchdog_time);
		$display("Something failed");
		$finish;
	end

	initial begin
		cache_pkg::tag_t seq [8];
		logic [31:0] r;
		reset = 1'b1;
		wr_en = 1'b0;
		wr_idx = '0;
		wr_tag = '0;
		wr_data = '0;
		rd_idx = '0;
		rd_tag = '0;
		repeat (reset_cycles) @(posedge clock);
		#(drive_delay);
		reset = 1'b0;

		// everything misses in the empty cache
		for (int s = 0; s < cache_pkg::num_sets; s++) begin
			read_line(cache_pkg::set_idx_t'(s), random_tag());
			read_line(cache_pkg::set_idx_t'(s), random_tag());
		end

		// one line per set with a read back and a miss on another tag
		for (int s = 0; s < cache_pkg::num_sets; s++) begin
			write_line(cache_pkg::set_idx_t'(s), cache_pkg::tag_t'(256 + s), random_data());
			read_line(cache_pkg::set_idx_t'(s), cache_pkg::tag_t'(256 + s));
			read_line(cache_pkg::set_idx_t'(s), cache_pkg::tag_t'(512 + s));
		end

		// overwrite an existing tag in set 2
		write_line(3'd2, 10'd300, random_data());
		write_line(3'd2, 10'd301, random_data());
		write_line(3'd2, 10'd258, random_data());
		read_line(3'd2, 10'd258);
		read_line(3'd2, 10'd300);
		read_line(3'd2, 10'd301);

		// set 5 already holds tag 261 in way 0
		seq[0] = 10'd261;
		for (int k = 1; k < 8; k++) begin
			seq[k] = cache_pkg::tag_t'(400 + k);
		end
		for (int k = 0; k < 5; k++) begin
			write_line(3'd5, seq[k], random_data());
		end
		for (int k = 0; k < 5; k++) begin
			read_line(3'd5, seq[k]);
		end
		for (int k = 5; k < 8; k++) begin
			write_line(3'd5, seq[k], random_data());
		end
		for (int k = 0; k < 8; k++) begin
			read_line(3'd5, seq[k]);
		end

		// read and write the same set in one cycle
		drive_cycle(1'b1, 3'd7, 10'd500, random_data(), 3'd7, 10'd500);
		read_line(3'd7, 10'd500);
		drive_cycle(1'b1, 3'd7, 10'd263, random_data(), 3'd7, 10'd263);
		read_line(3'd7, 10'd263);

		// random traffic over a small tag range for frequent hits and evictions
		repeat (random_cycles) begin
			r = $random(seed);
			drive_cycle(r[0], r[3:1], cache_pkg::tag_t'(r[15:8] % 6), random_data(),
				r[6:4], cache_pkg::tag_t'(r[23:16] % 6));
		end

		drive_cycle(1'b0, '0, '0, '0, '0, '0);
		drive_cycle(1'b0, '0, '0, '0, '0, '0);
		@(posedge clock);

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
